// File: sim.f
+incdir+hw
hw/rv_pkg.sv
hw/alu.sv
hw/regfile.sv
hw/inst_decoder.sv
hw/core_fsm.sv
hw/perf_counter.sv
hw/rvcpu.sv
test/rvcpu_sva.sv
test/rvcpu_checker.sv
test/tb_rvcpu.sv

// File: Bender.yml
package:
  name: rvcpu

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/alu.sv
      - hw/regfile.sv
      - hw/inst_decoder.sv
      - hw/core_fsm.sv
      - hw/perf_counter.sv
      - hw/rvcpu.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/rvcpu_sva.sv
      - test/rvcpu_checker.sv
      - test/tb_rvcpu.sv

// File: test/tb_rvcpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module tb_rvcpu;
	import rv_pkg::*;

	localparam int PROG_WORDS = 512;
	localparam int N_COMMITS = 800;
	localparam int CLK_PERIOD = 40;
	// worst case about 12 cycles per instruction, plus a margin
	localparam longint WATCHDOG_NS = (N_COMMITS * 12 + 2000) * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst_n = 1'b0;

	logic             if_ready = 1'b0;
	logic [1:0]       if_resp = `RESP_OKAY;
	logic [31:0]      if_data_read = '0;
	wire              if_valid;
	wire [31:0]       if_addr;
	wire [1:0]        if_size;
	logic             mem_ready = 1'b0;
	logic [1:0]       mem_resp = `RESP_OKAY;
	logic [31:0]      mem_data_read = '0;
	wire              mem_valid;
	wire [1:0]        mem_req;
	wire [31:0]       mem_addr;
	wire [31:0]       mem_data_write;
	wire [1:0]        mem_size;
	wire              diff_wb_inst_valid;
	wire [31:0]       diff_wb_pc;
	wire [31:0]       diff_wb_inst;
	wire              diff_wb_rd_wena;
	wire [4:0]        diff_wb_rd_waddr;
	wire [31:0]       diff_wb_rd_data;
	wire              diff_trap;
	wire [31:0]       diff_cycle;
	wire [31:0]       diff_instret;
	commit_t          trace;

	logic [31:0] imem [PROG_WORDS];
	logic [31:0] dmem [32];
	logic [31:0] lcg_state;
	logic [1:0]  if_wait;
	logic [1:0]  mem_wait;
	int          errors;
	int          commits;

	always #(CLK_PERIOD / 2) clk = ~clk;

	rvcpu DUT (.*);

	assign trace = {diff_wb_pc, diff_wb_inst, diff_wb_rd_wena, diff_wb_rd_waddr,
		diff_wb_rd_data, diff_trap};

	rvcpu_checker u_checker (
		.clk                (clk),
		.rst_n              (rst_n),
		.diff_wb_inst_valid (diff_wb_inst_valid),
		.trace              (trace),
		.diff_instret       (diff_instret),
		.diff_cycle         (diff_cycle),
		.if_valid           (if_valid),
		.if_addr            (if_addr),
		.if_size            (if_size),
		.mem_valid          (mem_valid),
		.mem_ready          (mem_ready),
		.mem_req            (mem_req),
		.mem_addr           (mem_addr),
		.mem_data_write     (mem_data_write),
		.mem_size           (mem_size),
		.errors             (errors),
		.commits            (commits)
	);

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'b0, lcg_state[31:16]};
	endfunction

	function logic [31:0] data_fill(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'hc0de_0000;
	endfunction

	function logic [31:0] make_b_type(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
	endfunction

	function logic [31:0] make_j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] off;
		logic [2:0]  f3_imm [5];
		logic [9:0]  reg_ops [10];
		f3_imm = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
		// funct7 bit 5 and funct3 for each register op
		reg_ops = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004,
			10'h002, 10'h003, 10'h001, 10'h005, 10'h105};
		for (int i = 0; i < PROG_WORDS; i++) begin
			r = next_rand();
			rd = 5'(next_rand());
			rs1 = 5'(next_rand());
			rs2 = 5'(next_rand());
			off = 12'h400 + {5'(next_rand()), 2'b00};
			case (r % 32)
				0: imem[i] = {25'(next_rand()), 7'h7f};
				10, 11, 12, 13, 14, 15:
					imem[i] = {12'(next_rand()), rs1, f3_imm[next_rand() % 5], rd, 7'h13};
				16, 17: imem[i] = {20'(next_rand() ^ (next_rand() << 16)), rd, 7'h37};
				18, 19, 20: imem[i] = {off, 5'd0, 3'd2, rd, 7'h03};
				21, 22, 23: imem[i] = {off[11:5], rs2, 5'd0, 3'd2, off[4:0], 7'h23};
				24, 25, 26, 27:
					imem[i] = make_b_type(13'(4 * (1 + next_rand() % 4)), rs2, rs1, 3'(r[5]));
				28, 29: imem[i] = make_j_type(21'(4 * (1 + next_rand() % 4)), rd);
				default: begin
					r = reg_ops[next_rand() % 10];
					imem[i] = {1'b0, r[8], 5'b0, rs2, rs1, r[2:0], rd, 7'h33};
				end
			endcase
		end
	endtask

	// fetch and data bus models, one wait counter each
	always @(posedge clk) begin
		if (!rst_n) begin
			if_ready <= 1'b0;
			mem_ready <= 1'b0;
			if_wait <= 2'd0;
			mem_wait <= 2'd0;
		end else begin
			if (if_ready) begin
				if_ready <= 1'b0;
			end else if (if_valid) begin
				if (if_wait == 2'd0) begin
					if_ready <= 1'b1;
					if_resp <= `RESP_OKAY;
					if_data_read <= imem[if_addr[10:2]];
					if_wait <= 2'(next_rand());
				end else begin
					if_wait <= if_wait - 2'd1;
				end
			end
			if (mem_ready) begin
				mem_ready <= 1'b0;
			end else if (mem_valid) begin
				if (mem_wait == 2'd0) begin
					mem_ready <= 1'b1;
					mem_wait <= 2'(next_rand());
					mem_data_read <= dmem[mem_addr[6:2]];
					if (mem_addr == 32'h0000_047c) begin
						mem_resp <= `RESP_ERR;
					end else begin
						mem_resp <= `RESP_OKAY;
						if (mem_req == `MEM_REQ_WRITE) begin
							dmem[mem_addr[6:2]] <= mem_data_write;
						end
					end
				end else begin
					mem_wait <= mem_wait - 2'd1;
				end
			end
		end
	end

	initial begin
		lcg_state = 32'd26;
		build_program();
		for (int i = 0; i < 32; i++) begin
			dmem[i] = data_fill(32'h0000_0400 + 4 * i);
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		while (commits < N_COMMITS) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("commits %0d, errors %0d, assertion failures %0d", commits, errors,
			DUT.u_rvcpu_sva.fail_count);
		if (errors == 0 && DUT.u_rvcpu_sva.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the core stopped committing after %0d instructions", commits);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/rvcpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rvcpu_checker (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  diff_wb_inst_valid,
	input  wire rv_pkg::commit_t trace,
	input  wire [31:0]           diff_instret,
	input  wire [31:0]           diff_cycle,
	input  wire                  if_valid,
	input  wire [31:0]           if_addr,
	input  wire [1:0]            if_size,
	input  wire                  mem_valid,
	input  wire                  mem_ready,
	input  wire [1:0]            mem_req,
	input  wire [31:0]           mem_addr,
	input  wire [31:0]           mem_data_write,
	input  wire [1:0]            mem_size,
	output int                   errors,
	output int                   commits
);
	import rv_pkg::*;

	logic [31:0] m_x [32];
	logic [31:0] m_dmem [32];
	logic [31:0] m_pc;
	logic [31:0] m_cycle;
	logic [31:0] hs_addr;
	logic [31:0] hs_data;
	logic [1:0]  hs_req;
	logic        hs_seen;
	logic        instret_due;
	logic        first_fetch_seen;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// the last data handshake must match the committed load or store
	task automatic check_request(input logic [1:0] req, input logic [31:0] addr);
		if (!hs_seen) begin
			errors++;
			$display("a load or store committed without a data handshake");
		end else begin
			check_value("data request kind", 32'(req), 32'(hs_req));
			check_value("data address", addr, hs_addr);
		end
	endtask

	// reference execution of the instruction at the model pc
	task automatic execute_commit();
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] addr;
		logic [31:0] val;
		logic [31:0] npc;
		logic        trap;
		logic        we;
		inst = tb_rvcpu.imem[m_pc[10:2]];
		a = m_x[inst[19:15]];
		b = m_x[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		npc = m_pc + 4;
		trap = 1'b0;
		we = 1'b0;
		val = '0;
		case (inst[6:0])
			7'h33: begin
				we = 1'b1;
				case ({inst[31:25], inst[14:12]})
					10'h000: val = a + b;
					10'h100: val = a - b;
					10'h007: val = a & b;
					10'h006: val = a | b;
					10'h004: val = a ^ b;
					10'h002: val = 32'($signed(a) < $signed(b));
					10'h003: val = 32'(a < b);
					10'h001: val = a << b[4:0];
					10'h005: val = a >> b[4:0];
					10'h105: val = $signed(a) >>> b[4:0];
					default: trap = 1'b1;
				endcase
			end
			7'h13: begin
				we = 1'b1;
				case (inst[14:12])
					3'd0: val = a + imm_i;
					3'd7: val = a & imm_i;
					3'd6: val = a | imm_i;
					3'd4: val = a ^ imm_i;
					3'd2: val = 32'($signed(a) < $signed(imm_i));
					default: trap = 1'b1;
				endcase
			end
			7'h37: begin
				we = 1'b1;
				val = {inst[31:12], 12'b0};
			end
			7'h03: begin
				we = 1'b1;
				addr = a + imm_i;
				trap = (inst[14:12] != 3'd2) || (addr == 32'h0000_047c);
				val = m_dmem[addr[6:2]];
				if (!trap) begin
					check_request(`MEM_REQ_READ, addr);
				end
			end
			7'h23: begin
				addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				trap = (inst[14:12] != 3'd2) || (addr == 32'h0000_047c);
				if (!trap) begin
					check_request(`MEM_REQ_WRITE, addr);
					check_value("store data", b, hs_data);
					m_dmem[addr[6:2]] = b;
				end
			end
			7'h63: begin
				trap = inst[14:13] != 2'd0;
				if ((a == b) != inst[12]) begin
					npc = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				end
			end
			7'h6f: begin
				we = 1'b1;
				val = m_pc + 4;
				npc = m_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: trap = 1'b1;
		endcase
		if (trap) begin
			we = 1'b0;
			npc = `TRAP_VEC;
		end
		check_value("commit pc", m_pc, trace.pc);
		check_value("commit inst", inst, trace.inst);
		check_value("trap flag", 32'(trap), 32'(trace.trap));
		check_value("rd write enable", 32'(we), 32'(trace.rd_wena));
		if (we) begin
			check_value("rd address", 32'(inst[11:7]), 32'(trace.rd_waddr));
			check_value("rd data", val, trace.rd_data);
			if (inst[11:7] != 5'd0) begin
				m_x[inst[11:7]] = val;
			end
		end
		m_pc = npc;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				m_x[i] = '0;
				m_dmem[i] = tb_rvcpu.data_fill(32'h0000_0400 + 4 * i);
			end
			m_pc = `RESET_PC;
			m_cycle = '0;
			errors = 0;
			commits = 0;
			hs_seen = 1'b0;
			instret_due = 1'b0;
			first_fetch_seen = 1'b0;
		end else begin
			// one count per clock after reset release
			check_value("cycle count", m_cycle, diff_cycle);
			m_cycle = m_cycle + 32'd1;
			if (if_valid && !first_fetch_seen) begin
				check_value("first fetch address", `RESET_PC, if_addr);
				first_fetch_seen = 1'b1;
			end
			if (if_valid) begin
				check_value("fetch size", 32'(`SIZE_WORD), 32'(if_size));
			end
			if (mem_valid) begin
				check_value("data size", 32'(`SIZE_WORD), 32'(mem_size));
			end
			if (instret_due) begin
				check_value("instret", commits, diff_instret);
				instret_due = 1'b0;
			end
			if (mem_valid && mem_ready) begin
				hs_addr = mem_addr;
				hs_data = mem_data_write;
				hs_req = mem_req;
				hs_seen = 1'b1;
			end
			if (diff_wb_inst_valid) begin
				execute_commit();
				hs_seen = 1'b0;
				commits++;
				instret_due = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: test/rvcpu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rvcpu_sva (
	input wire        clk,
	input wire        rst_n,
	input wire        if_valid,
	input wire        if_ready,
	input wire [31:0] if_addr,
	input wire        mem_valid,
	input wire        mem_ready,
	input wire [1:0]  mem_req,
	input wire [31:0] mem_addr,
	input wire [31:0] mem_data_write
);

	int fail_count = 0;

	// a request may not change or drop while it waits
	assert property (@(posedge clk) disable iff (!rst_n)
		if_valid && !if_ready |=> if_valid && $stable(if_addr))
		else begin
			$error("fetch request changed while waiting for ready");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_req)
			&& $stable(mem_data_write))
		else begin
			$error("data request changed while waiting for ready");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n) !(if_valid && mem_valid))
		else begin
			$error("fetch and data requests active together");
			fail_count++;
		end

	assert property (@(posedge clk) $rose(rst_n) |-> !if_valid && !mem_valid)
		else begin
			$error("request active right after reset");
			fail_count++;
		end

endmodule

bind rvcpu rvcpu_sva u_rvcpu_sva (.*);

`default_nettype wire

// File: hw/rvcpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rvcpu (
	input  wire                   clk,
	input  wire                   rst_n,

	// instruction fetch port
	input  wire                   if_ready,
	input  wire [1:0]             if_resp,
	input  wire [`XLEN-1:0]       if_data_read,
	output wire                   if_valid,
	output wire [`XLEN-1:0]       if_addr,
	output wire [1:0]             if_size,

	// data port
	input  wire                   mem_ready,
	input  wire [1:0]             mem_resp,
	input  wire [`XLEN-1:0]       mem_data_read,
	output wire                   mem_valid,
	output wire [1:0]             mem_req,
	output wire [`XLEN-1:0]       mem_addr,
	output wire [`XLEN-1:0]       mem_data_write,
	output wire [1:0]             mem_size,

	// commit trace
	output wire                   diff_wb_inst_valid,
	output wire [`XLEN-1:0]       diff_wb_pc,
	output wire [31:0]            diff_wb_inst,
	output wire                   diff_wb_rd_wena,
	output wire [4:0]             diff_wb_rd_waddr,
	output wire [`XLEN-1:0]       diff_wb_rd_data,
	output wire                   diff_trap,
	output wire [`XLEN-1:0]       diff_cycle,
	output wire [`XLEN-1:0]       diff_instret
);
	import rv_pkg::*;

	decode_t          dec;
	logic [31:0]      inst;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] alu_a;
	logic [`XLEN-1:0] alu_b;
	alu_op_e          alu_op;
	logic [`XLEN-1:0] alu_result;
	logic             alu_cond;
	logic             rd_wena;
	logic [4:0]       rd_waddr;
	logic [`XLEN-1:0] rd_wdata;
	commit_t          commit;

	core_fsm u_core_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.if_ready       (if_ready),
		.if_resp        (if_resp),
		.if_data_read   (if_data_read),
		.if_valid       (if_valid),
		.if_addr        (if_addr),
		.if_size        (if_size),
		.mem_ready      (mem_ready),
		.mem_resp       (mem_resp),
		.mem_data_read  (mem_data_read),
		.mem_valid      (mem_valid),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_data_write (mem_data_write),
		.mem_size       (mem_size),
		.dec            (dec),
		.inst           (inst),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.alu_op         (alu_op),
		.alu_result     (alu_result),
		.alu_cond       (alu_cond),
		.rd_wena        (rd_wena),
		.rd_waddr       (rd_waddr),
		.rd_wdata       (rd_wdata),
		.commit         (commit),
		.retire         (diff_wb_inst_valid)
	);

	inst_decoder u_inst_decoder (
		.inst (inst),
		.dec  (dec)
	);

	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.w_ena   (rd_wena),
		.w_addr  (rd_waddr),
		.w_data  (rd_wdata),
		.r_addr1 (dec.rs1_addr),
		.r_addr2 (dec.rs2_addr),
		.r_data1 (rs1_data),
		.r_data2 (rs2_data)
	);

	alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.cond   (alu_cond)
	);

	perf_counter u_perf_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.retire  (diff_wb_inst_valid),
		.cycle   (diff_cycle),
		.instret (diff_instret)
	);

	// trace fields out of the commit record
	assign diff_wb_pc = commit.pc;
	assign diff_wb_inst = commit.inst;
	assign diff_wb_rd_wena = commit.rd_wena;
	assign diff_wb_rd_waddr = commit.rd_waddr;
	assign diff_wb_rd_data = commit.rd_data;
	assign diff_trap = commit.trap;

endmodule

`default_nettype wire

// File: hw/perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module perf_counter (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   retire,
	output logic [`XLEN-1:0]      cycle,
	output logic [`XLEN-1:0]      instret
);

	// both wrap silently
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= '0;
			instret <= '0;
		end else begin
			cycle <= cycle + `XLEN'd1;
			if (retire) begin
				instret <= instret + `XLEN'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/core_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module core_fsm (
	input  wire                   clk,
	input  wire                   rst_n,
	// instruction fetch port
	input  wire                   if_ready,
	input  wire [1:0]             if_resp,
	input  wire [`XLEN-1:0]       if_data_read,
	output logic                  if_valid,
	output logic [`XLEN-1:0]      if_addr,
	output logic [1:0]            if_size,
	// data port
	input  wire                   mem_ready,
	input  wire [1:0]             mem_resp,
	input  wire [`XLEN-1:0]       mem_data_read,
	output logic                  mem_valid,
	output logic [1:0]            mem_req,
	output logic [`XLEN-1:0]      mem_addr,
	output logic [`XLEN-1:0]      mem_data_write,
	output logic [1:0]            mem_size,
	// decoder
	input  wire rv_pkg::decode_t  dec,
	output logic [31:0]           inst,
	// register file and alu
	input  wire [`XLEN-1:0]       rs1_data,
	input  wire [`XLEN-1:0]       rs2_data,
	output logic [`XLEN-1:0]      alu_a,
	output logic [`XLEN-1:0]      alu_b,
	output rv_pkg::alu_op_e       alu_op,
	input  wire [`XLEN-1:0]       alu_result,
	input  wire                   alu_cond,
	output logic                  rd_wena,
	output logic [4:0]            rd_waddr,
	output logic [`XLEN-1:0]      rd_wdata,
	// commit trace
	output rv_pkg::commit_t       commit,
	output logic                  retire
);
	import rv_pkg::*;

	core_state_e      state;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] target;
	logic [`XLEN-1:0] next_pc;
	logic [`XLEN-1:0] result_q;
	logic [`XLEN-1:0] load_q;
	logic             taken;

	assign pc_plus4 = pc + `XLEN'd4;
	// branch and jal share the pc-relative target
	assign target = pc + dec.imm;
	assign taken = dec.jump | (dec.branch & alu_cond);

	// operand select, jal passes pc+4 through to rd
	assign alu_a = dec.lui ? '0 : rs1_data;
	assign alu_b = dec.jump ? pc_plus4 : (dec.op2_imm ? dec.imm : rs2_data);
	assign alu_op = dec.alu_op;

	assign if_addr = pc;
	assign if_size = `SIZE_WORD;

	// address held in result_q and rs2 unchanged until writeback
	assign mem_addr = result_q;
	assign mem_data_write = rs2_data;
	assign mem_req = dec.mem_wena ? `MEM_REQ_WRITE : `MEM_REQ_READ;
	assign mem_size = `SIZE_WORD;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_fetch;
			pc <= `RESET_PC;
			if_valid <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!if_valid) begin
						// first request out of reset
						if_valid <= 1'b1;
					end else if (if_ready) begin
						if_valid <= 1'b0;
						state <= (if_resp != `RESP_OKAY) ? st_trap : st_decode;
					end
				end
				st_decode: begin
					state <= dec.illegal ? st_trap : st_execute;
				end
				st_execute: begin
					if (dec.mem_rena || dec.mem_wena) begin
						mem_valid <= 1'b1;
						state <= st_mem;
					end else begin
						state <= st_writeback;
					end
				end
				st_mem: begin
					if (mem_ready) begin
						mem_valid <= 1'b0;
						state <= (mem_resp != `RESP_OKAY) ? st_trap : st_writeback;
					end
				end
				st_writeback: begin
					pc <= next_pc;
					if_valid <= 1'b1;
					state <= st_fetch;
				end
				st_trap: begin
					pc <= `TRAP_VEC;
					if_valid <= 1'b1;
					state <= st_fetch;
				end
				default: begin
					state <= st_trap;
				end
			endcase
		end
	end

	// instruction, alu result, next pc and load data
	always_ff @(posedge clk) begin
		if (state == st_fetch && if_valid && if_ready) begin
			inst <= if_data_read;
		end
		if (state == st_execute) begin
			result_q <= alu_result;
			next_pc <= taken ? target : pc_plus4;
		end
		if (state == st_mem && mem_ready) begin
			load_q <= mem_data_read;
		end
	end

	// write lands on the edge that leaves writeback
	assign rd_wena = (state == st_writeback) && dec.rd_wena;
	assign rd_waddr = dec.rd_addr;
	assign rd_wdata = dec.mem_rena ? load_q : result_q;

	assign retire = (state == st_writeback) || (state == st_trap);

	always_comb begin
		commit.pc = pc;
		commit.inst = inst;
		commit.rd_wena = rd_wena;
		commit.rd_waddr = rd_waddr;
		commit.rd_data = rd_wdata;
		commit.trap = (state == st_trap);
	end

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  wire [31:0]      inst,
	output rv_pkg::decode_t dec
);
	import rv_pkg::*;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_reg    = 7'b0110011,
		opc_imm    = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec = '0;
		dec.alu_op = alu_add;
		dec.rs1_addr = inst[19:15];
		dec.rs2_addr = inst[24:20];
		dec.rd_addr = inst[11:7];
		case (opcode)
			opc_reg: begin
				dec.rd_wena = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: dec.alu_op = alu_add;
					{7'b0100000, 3'b000}: dec.alu_op = alu_sub;
					{7'b0000000, 3'b111}: dec.alu_op = alu_and;
					{7'b0000000, 3'b110}: dec.alu_op = alu_or;
					{7'b0000000, 3'b100}: dec.alu_op = alu_xor;
					{7'b0000000, 3'b010}: dec.alu_op = alu_slt;
					{7'b0000000, 3'b011}: dec.alu_op = alu_sltu;
					{7'b0000000, 3'b001}: dec.alu_op = alu_sll;
					{7'b0000000, 3'b101}: dec.alu_op = alu_srl;
					{7'b0100000, 3'b101}: dec.alu_op = alu_sra;
					default: dec.illegal = 1'b1;
				endcase
			end
			opc_imm: begin
				dec.rd_wena = 1'b1;
				dec.op2_imm = 1'b1;
				dec.imm = imm_i;
				case (funct3)
					3'b000: dec.alu_op = alu_add;
					3'b111: dec.alu_op = alu_and;
					3'b110: dec.alu_op = alu_or;
					3'b100: dec.alu_op = alu_xor;
					3'b010: dec.alu_op = alu_slt;
					default: dec.illegal = 1'b1;
				endcase
			end
			opc_lui: begin
				// zero plus the upper immediate
				dec.rd_wena = 1'b1;
				dec.op2_imm = 1'b1;
				dec.lui = 1'b1;
				dec.imm = imm_u;
			end
			opc_load: begin
				dec.rd_wena = 1'b1;
				dec.mem_rena = 1'b1;
				dec.op2_imm = 1'b1;
				dec.imm = imm_i;
				dec.illegal = (funct3 != 3'b010);
			end
			opc_store: begin
				dec.mem_wena = 1'b1;
				dec.op2_imm = 1'b1;
				dec.imm = imm_s;
				dec.illegal = (funct3 != 3'b010);
			end
			opc_branch: begin
				dec.branch = 1'b1;
				dec.imm = imm_b;
				case (funct3)
					3'b000: dec.alu_op = alu_eq;
					3'b001: dec.alu_op = alu_ne;
					default: dec.illegal = 1'b1;
				endcase
			end
			opc_jal: begin
				dec.jump = 1'b1;
				dec.rd_wena = 1'b1;
				dec.imm = imm_j;
				dec.alu_op = alu_pass_b;
			end
			default: begin
				dec.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module regfile (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   w_ena,
	input  wire [4:0]             w_addr,
	input  wire [`XLEN-1:0]       w_data,
	input  wire [4:0]             r_addr1,
	input  wire [4:0]             r_addr2,
	output logic [`XLEN-1:0]      r_data1,
	output logic [`XLEN-1:0]      r_data2
);

	logic [`XLEN-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (w_ena && w_addr != 5'd0) begin
			// x0 stays zero
			regs[w_addr] <= w_data;
		end
	end

	assign r_data1 = regs[r_addr1];
	assign r_data2 = regs[r_addr2];

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module alu (
	input  wire rv_pkg::alu_op_e  op,
	input  wire [`XLEN-1:0]       a,
	input  wire [`XLEN-1:0]       b,
	output logic [`XLEN-1:0]      result,
	output logic                  cond
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	// branch condition, ne inverts the compare
	assign cond = (op == alu_ne) ? (a != b) : (a == b);

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_slt:    result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu:   result = {{(`XLEN-1){1'b0}}, a < b};
			alu_sll:    result = a << shamt;
			alu_srl:    result = a >> shamt;
			alu_sra:    result = $signed(a) >>> shamt;
			alu_eq:     result = {{(`XLEN-1){1'b0}}, cond};
			alu_ne:     result = {{(`XLEN-1){1'b0}}, cond};
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

	// alu operations, eq and ne also drive the branch condition
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_eq,
		alu_ne,
		alu_pass_b
	} alu_op_e;

	// phases of a single instruction
	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_mem,
		st_writeback,
		st_trap
	} core_state_e;

	typedef struct packed {
		alu_op_e     alu_op;
		logic [4:0]  rs1_addr;
		logic [4:0]  rs2_addr;
		logic [4:0]  rd_addr;
		logic [31:0] imm;
		logic        op2_imm;
		logic        rd_wena;
		logic        mem_rena;
		logic        mem_wena;
		logic        branch;
		logic        jump;
		logic        lui;
		logic        illegal;
	} decode_t;

	// one retired instruction as seen on the trace
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0]      inst;
		logic             rd_wena;
		logic [4:0]       rd_waddr;
		logic [`XLEN-1:0] rd_data;
		logic             trap;
	} commit_t;

endpackage

`default_nettype wire

// File: hw/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define XLEN 32

// pc after reset and after any trap
`define RESET_PC 32'h0000_0000
`define TRAP_VEC 32'h0000_0100

// two-bit response codes on both buses
`define RESP_OKAY 2'd0
`define RESP_ERR 2'd2

// only word accesses are issued
`define SIZE_WORD 2'd2

// data port request kinds
`define MEM_REQ_READ 2'd1
`define MEM_REQ_WRITE 2'd2

`endif
